// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' all.f) csr_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) all.f
	$(VERILATOR) $(VFLAGS) -f all.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+.
csr_pkg.sv
csr_write_queue.sv
csr_exception.sv
csr_timer.sv
csr_scratch.sv
csr_unit.sv
csr_assertions.sv
tb_csr_unit.sv

// ==== csr_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "csr_defs.svh"

module csr_assertions (
    input wire                     clk,
    input wire                     aresetn,
    input wire                     wr_valid,
    input wire                     wr_ready,
    input wire                     flush,
    input wire                     commit_we,
    input wire                     cpu_interrupt,
    input wire csr_pkg::csr_word_t crmd
);

    // Accepted write blocks the port until it commits or is flushed
    property pending_blocks_ready;
        @(posedge clk) disable iff (!aresetn)
        ((wr_valid && wr_ready) || (!wr_ready && !commit_we)) && !flush |=> !wr_ready;
    endproperty

    property commit_single_cycle;
        @(posedge clk) disable iff (!aresetn)
        commit_we |=> !commit_we;
    endproperty

    property interrupt_needs_ie;
        @(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[`CRMD_IE];
    endproperty

    a_pending: assert property (pending_blocks_ready) else $error("wr_ready high while pending");
    a_commit:  assert property (commit_single_cycle) else $error("commit_we longer than one cycle");
    a_irq:     assert property (interrupt_needs_ie) else $error("cpu_interrupt without CRMD.IE");

endmodule

`default_nettype wire

// ==== csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Word and bus widths
`define CSR_DATA_W      32
`define CSR_ADDR_W      14
`define HW_INT_W        8
`define IS_W            13
`define ECODE_W         6
`define ESUBCODE_W      9
`define INITVAL_W       30
`define EENTRY_VA_W     26

// Idle cycles a buffered write waits for
`define WR_COMMIT_IDLE  3

// LIE bit 10 is reserved
`define ECFG_LIE_MASK   13'h1bff

// CRMD
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DATF       6:5
`define CRMD_DATM       8:7

// PRMD
`define PRMD_PPLV       1:0
`define PRMD_PIE        2

// ESTAT
`define ESTAT_IS_SOFT   1:0
`define ESTAT_IS_HARD   9:2
`define ESTAT_IS_TI     11
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22

// Timer
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0

// EENTRY
`define EENTRY_VA       31:6

`endif

// ==== csr_exception.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "csr_defs.svh"

module csr_exception (
    input  wire                       clk,
    input  wire                       aresetn,
    input  wire                       commit_we,
    input  wire csr_pkg::csr_addr_e   commit_addr,
    input  wire csr_pkg::csr_word_t   commit_data,
    input  wire                       exception,
    input  wire                       ertn,
    input  wire csr_pkg::ecode_e      ecode_in,
    input  wire [`ESUBCODE_W-1:0]     esubcode_in,
    input  wire csr_pkg::csr_word_t   era_in,
    input  wire csr_pkg::csr_word_t   badv_in,
    input  wire                       badv_we,
    input  wire [`HW_INT_W-1:0]       hw_int,
    input  wire                       timer_int,
    input  wire csr_pkg::csr_addr_e   rd_addr,
    output csr_pkg::csr_word_t        rd_data_exc,
    output csr_pkg::csr_word_t        crmd,
    output csr_pkg::csr_word_t        estat,
    output csr_pkg::csr_word_t        era,
    output csr_pkg::csr_word_t        eentry,
    output logic                      cpu_interrupt,
    output logic                      idle_over
);
    import csr_pkg::*;

    logic                   exc_q;
    logic                   exc_entry;
    plv_t                   crmd_plv;
    logic                   crmd_ie;
    logic                   crmd_da;
    logic                   crmd_pg;
    logic [1:0]             crmd_datf;
    logic [1:0]             crmd_datm;
    plv_t                   prmd_pplv;
    logic                   prmd_pie;
    logic [`IS_W-1:0]       ecfg_lie;
    logic [1:0]             estat_soft;
    ecode_e                 estat_ecode;
    logic [`ESUBCODE_W-1:0] estat_esubcode;
    csr_word_t              badv_q;
    logic [`EENTRY_VA_W-1:0] eentry_va;
    csr_word_t              prmd_w;
    logic                   wr_pg;
    logic                   wr_da;

    // Entry on the rising edge of exception, ertn wins over it
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exc_q <= 1'b0;
        end else begin
            exc_q <= exception;
        end
    end

    assign exc_entry = exception && !exc_q && !ertn;

    assign wr_pg = commit_data[`CRMD_PG];
    assign wr_da = commit_data[`CRMD_DA];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (exc_entry) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (commit_we && commit_addr == CSR_CRMD) begin
            crmd_plv  <= commit_data[`CRMD_PLV];
            crmd_ie   <= commit_data[`CRMD_IE];
            crmd_datf <= commit_data[`CRMD_DATF];
            crmd_datm <= commit_data[`CRMD_DATM];
            // Only direct or paged mode, never both or neither
            if (wr_pg ^ wr_da) begin
                crmd_pg <= wr_pg;
                crmd_da <= wr_da;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
            era       <= '0;
        end else if (exc_entry) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            era       <= era_in;
        end else if (commit_we) begin
            if (commit_addr == CSR_PRMD) begin
                prmd_pplv <= commit_data[`PRMD_PPLV];
                prmd_pie  <= commit_data[`PRMD_PIE];
            end
            if (commit_addr == CSR_ERA) begin
                era <= commit_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_ecode    <= ECODE_INT;
            estat_esubcode <= '0;
        end else if (exc_entry) begin
            estat_ecode    <= ecode_in;
            estat_esubcode <= (ecode_in != ECODE_INT) ? esubcode_in : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_soft <= '0;
            ecfg_lie   <= '0;
            eentry_va  <= '0;
            badv_q     <= '0;
        end else begin
            if (commit_we && commit_addr == CSR_ESTAT) begin
                estat_soft <= commit_data[`ESTAT_IS_SOFT];
            end
            if (commit_we && commit_addr == CSR_ECFG) begin
                ecfg_lie <= commit_data[`IS_W-1:0] & `ECFG_LIE_MASK;
            end
            if (commit_we && commit_addr == CSR_EENTRY) begin
                eentry_va <= commit_data[`EENTRY_VA];
            end
            if (badv_we) begin
                badv_q <= badv_in;
            end else if (commit_we && commit_addr == CSR_BADV) begin
                badv_q <= commit_data;
            end
        end
    end

    always_comb begin
        crmd = '0;
        crmd[`CRMD_PLV]  = crmd_plv;
        crmd[`CRMD_IE]   = crmd_ie;
        crmd[`CRMD_DA]   = crmd_da;
        crmd[`CRMD_PG]   = crmd_pg;
        crmd[`CRMD_DATF] = crmd_datf;
        crmd[`CRMD_DATM] = crmd_datm;

        prmd_w = '0;
        prmd_w[`PRMD_PPLV] = prmd_pplv;
        prmd_w[`PRMD_PIE]  = prmd_pie;

        // Hard lines and TI are live inputs, not stored
        estat = '0;
        estat[`ESTAT_IS_SOFT]  = estat_soft;
        estat[`ESTAT_IS_HARD]  = hw_int;
        estat[`ESTAT_IS_TI]    = timer_int;
        estat[`ESTAT_ECODE]    = estat_ecode;
        estat[`ESTAT_ESUBCODE] = estat_esubcode;

        eentry = '0;
        eentry[`EENTRY_VA] = eentry_va;
    end

    assign cpu_interrupt = crmd_ie && |(ecfg_lie & estat[`IS_W-1:0]);
    assign idle_over     = |estat[`IS_W-1:0];

    always_comb begin
        case (rd_addr)
            CSR_CRMD:   rd_data_exc = crmd;
            CSR_PRMD:   rd_data_exc = prmd_w;
            CSR_ECFG:   rd_data_exc = csr_word_t'(ecfg_lie);
            CSR_ESTAT:  rd_data_exc = estat;
            CSR_ERA:    rd_data_exc = era;
            CSR_BADV:   rd_data_exc = badv_q;
            CSR_EENTRY: rd_data_exc = eentry;
            default:    rd_data_exc = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
`default_nettype none
`include "csr_defs.svh"

package csr_pkg;

    typedef logic [`CSR_DATA_W-1:0] csr_word_t;

    typedef logic [1:0] plv_t;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // Subset of the architectural exception codes
    typedef enum logic [`ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_PIL = 6'h01,
        ECODE_PIS = 6'h02,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

endpackage

`default_nettype wire

// ==== csr_scratch.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_scratch (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire                     commit_we,
    input  wire csr_pkg::csr_addr_e commit_addr,
    input  wire csr_pkg::csr_word_t commit_data,
    input  wire csr_pkg::csr_addr_e rd_addr,
    output csr_pkg::csr_word_t      rd_data_scr
);
    import csr_pkg::*;

    csr_word_t save_q [4];
    csr_word_t tid_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
            tid_q <= '0;
        end else if (commit_we) begin
            case (commit_addr)
                CSR_SAVE0: save_q[0] <= commit_data;
                CSR_SAVE1: save_q[1] <= commit_data;
                CSR_SAVE2: save_q[2] <= commit_data;
                CSR_SAVE3: save_q[3] <= commit_data;
                CSR_TID:   tid_q     <= commit_data;
                default:   ;
            endcase
        end
    end

    always_comb begin
        case (rd_addr)
            CSR_SAVE0: rd_data_scr = save_q[0];
            CSR_SAVE1: rd_data_scr = save_q[1];
            CSR_SAVE2: rd_data_scr = save_q[2];
            CSR_SAVE3: rd_data_scr = save_q[3];
            CSR_TID:   rd_data_scr = tid_q;
            default:   rd_data_scr = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== csr_timer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "csr_defs.svh"

module csr_timer (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire                     commit_we,
    input  wire csr_pkg::csr_addr_e commit_addr,
    input  wire csr_pkg::csr_word_t commit_data,
    input  wire csr_pkg::csr_addr_e rd_addr,
    output csr_pkg::csr_word_t      rd_data_tmr,
    output logic                    timer_int
);
    import csr_pkg::*;

    logic                  tcfg_en;
    logic                  tcfg_periodic;
    logic [`INITVAL_W-1:0] tcfg_initval;
    logic                  tcfg_load;
    csr_word_t             tval;
    csr_word_t             tcfg_w;
    logic                  wr_tcfg;
    logic                  wr_ticlr;

    assign wr_tcfg  = commit_we && commit_addr == CSR_TCFG;
    assign wr_ticlr = commit_we && commit_addr == CSR_TICLR;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
            tcfg_load     <= 1'b0;
        end else begin
            tcfg_load <= wr_tcfg;
            if (wr_tcfg) begin
                tcfg_en       <= commit_data[`TCFG_EN];
                tcfg_periodic <= commit_data[`TCFG_PERIODIC];
                tcfg_initval  <= commit_data[`TCFG_INITVAL];
            end
        end
    end

    // Countdown restarts one cycle after TCFG is written
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval <= '0;
        end else if (tcfg_load) begin
            tval <= csr_word_t'(tcfg_initval);
        end else if (tcfg_en) begin
            if (tval != '0) begin
                tval <= tval - 1'b1;
            end else if (tcfg_periodic) begin
                tval <= csr_word_t'(tcfg_initval);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_int <= 1'b0;
        end else if (wr_ticlr && commit_data[`TICLR_CLR]) begin
            timer_int <= 1'b0;
        end else if (tcfg_en && !tcfg_load && tval == csr_word_t'(1)) begin
            timer_int <= 1'b1;
        end
    end

    always_comb begin
        tcfg_w = '0;
        tcfg_w[`TCFG_EN]       = tcfg_en;
        tcfg_w[`TCFG_PERIODIC] = tcfg_periodic;
        tcfg_w[`TCFG_INITVAL]  = tcfg_initval;
    end

    // TICLR reads as zero
    always_comb begin
        case (rd_addr)
            CSR_TCFG: rd_data_tmr = tcfg_w;
            CSR_TVAL: rd_data_tmr = tval;
            default:  rd_data_tmr = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "csr_defs.svh"

module csr_unit (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire                     wr_valid,
    output logic                    wr_ready,
    input  wire csr_pkg::csr_addr_e wr_addr,
    input  wire csr_pkg::csr_word_t wr_data,
    input  wire                     pipe_idle,
    input  wire                     flush,
    input  wire csr_pkg::csr_addr_e rd_addr,
    output csr_pkg::csr_word_t      rd_data,
    input  wire                     exception,
    input  wire                     ertn,
    input  wire csr_pkg::ecode_e    ecode_in,
    input  wire [`ESUBCODE_W-1:0]   esubcode_in,
    input  wire csr_pkg::csr_word_t era_in,
    input  wire csr_pkg::csr_word_t badv_in,
    input  wire                     badv_we,
    input  wire [`HW_INT_W-1:0]     hw_int,
    output csr_pkg::csr_word_t      crmd,
    output csr_pkg::csr_word_t      estat,
    output csr_pkg::csr_word_t      era,
    output csr_pkg::csr_word_t      eentry,
    output logic                    cpu_interrupt,
    output logic                    idle_over
);
    import csr_pkg::*;

    logic      commit_we;
    csr_addr_e commit_addr;
    csr_word_t commit_data;
    logic      timer_int;
    csr_word_t rd_data_exc;
    csr_word_t rd_data_tmr;
    csr_word_t rd_data_scr;

    csr_write_queue u_wq (
        .clk         (clk),
        .aresetn     (aresetn),
        .wr_valid    (wr_valid),
        .wr_ready    (wr_ready),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .pipe_idle   (pipe_idle),
        .flush       (flush),
        .commit_we   (commit_we),
        .commit_addr (commit_addr),
        .commit_data (commit_data)
    );

    csr_exception u_exc (
        .clk           (clk),
        .aresetn       (aresetn),
        .commit_we     (commit_we),
        .commit_addr   (commit_addr),
        .commit_data   (commit_data),
        .exception     (exception),
        .ertn          (ertn),
        .ecode_in      (ecode_in),
        .esubcode_in   (esubcode_in),
        .era_in        (era_in),
        .badv_in       (badv_in),
        .badv_we       (badv_we),
        .hw_int        (hw_int),
        .timer_int     (timer_int),
        .rd_addr       (rd_addr),
        .rd_data_exc   (rd_data_exc),
        .crmd          (crmd),
        .estat         (estat),
        .era           (era),
        .eentry        (eentry),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    csr_timer u_tmr (
        .clk         (clk),
        .aresetn     (aresetn),
        .commit_we   (commit_we),
        .commit_addr (commit_addr),
        .commit_data (commit_data),
        .rd_addr     (rd_addr),
        .rd_data_tmr (rd_data_tmr),
        .timer_int   (timer_int)
    );

    csr_scratch u_scr (
        .clk         (clk),
        .aresetn     (aresetn),
        .commit_we   (commit_we),
        .commit_addr (commit_addr),
        .commit_data (commit_data),
        .rd_addr     (rd_addr),
        .rd_data_scr (rd_data_scr)
    );

    // Each block returns zero for addresses it does not own
    assign rd_data = rd_data_exc | rd_data_tmr | rd_data_scr;

endmodule

`default_nettype wire

// ==== csr_write_queue.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "csr_defs.svh"

module csr_write_queue (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire                     wr_valid,
    output logic                    wr_ready,
    input  wire csr_pkg::csr_addr_e wr_addr,
    input  wire csr_pkg::csr_word_t wr_data,
    input  wire                     pipe_idle,
    input  wire                     flush,
    output logic                    commit_we,
    output csr_pkg::csr_addr_e      commit_addr,
    output csr_pkg::csr_word_t      commit_data
);

    localparam int CNT_W = $clog2(`WR_COMMIT_IDLE);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`WR_COMMIT_IDLE - 1);

    typedef enum logic {
        Q_EMPTY,
        Q_PENDING
    } q_state_e;

    q_state_e         state;
    logic [CNT_W-1:0] idle_cnt;
    logic             accept;

    assign wr_ready  = (state == Q_EMPTY);
    assign accept    = wr_valid && wr_ready;
    // Fires in the cycle after the last counted idle edge
    assign commit_we = (state == Q_PENDING) && (idle_cnt == CNT_LAST) && !flush;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state    <= Q_EMPTY;
            idle_cnt <= '0;
        end else if (flush) begin
            state    <= Q_EMPTY;
            idle_cnt <= '0;
        end else if (accept) begin
            state    <= Q_PENDING;
            idle_cnt <= '0;
        end else if (commit_we) begin
            state    <= Q_EMPTY;
            idle_cnt <= '0;
        end else if (state == Q_PENDING && pipe_idle) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit_addr <= wr_addr;
            commit_data <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== tb_csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "csr_defs.svh"

module tb_csr_unit;
    import csr_pkg::*;

    localparam int CLK_NS      = 100;
    localparam int TEST_CYCLES = 6 * 150 + 20;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_NS;

    logic                   clk;
    logic                   aresetn;
    logic                   wr_valid;
    logic                   wr_ready;
    csr_addr_e              wr_addr;
    csr_word_t              wr_data;
    logic                   pipe_idle;
    logic                   flush;
    csr_addr_e              rd_addr;
    csr_word_t              rd_data;
    logic                   exception;
    logic                   ertn;
    ecode_e                 ecode_in;
    logic [`ESUBCODE_W-1:0] esubcode_in;
    csr_word_t              era_in;
    csr_word_t              badv_in;
    logic                   badv_we;
    logic [`HW_INT_W-1:0]   hw_int;
    csr_word_t              crmd;
    csr_word_t              estat;
    csr_word_t              era;
    csr_word_t              eentry;
    logic                   cpu_interrupt;
    logic                   idle_over;

    int        errors;
    int        checks;
    int        errors_at_start;
    logic [15:0] lfsr_state;

    csr_unit dut0 (.*);

    bind csr_unit csr_assertions u_assert (
        .clk           (clk),
        .aresetn       (aresetn),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .flush         (flush),
        .commit_we     (commit_we),
        .cpu_interrupt (cpu_interrupt),
        .crmd          (crmd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]} ^ (b ? 16'hB400 : 16'h0000);
        return b;
    endfunction

    function automatic csr_word_t rand_word();
        csr_word_t w;
        for (int i = 0; i < `CSR_DATA_W; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic check_word(input string what, input csr_word_t got, input csr_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ecode(input string what, input ecode_e got, input ecode_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s: got %s expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Called just after a falling edge
    task automatic read_csr(input csr_addr_e addr, output csr_word_t data);
        rd_addr = addr;
        #1;
        data = rd_data;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!wr_ready && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!wr_ready) begin
            errors++;
            $display("Write queue never raised wr_ready again at %0d ns", $time);
        end
    endtask

    task automatic write_csr(input csr_addr_e addr, input csr_word_t data);
        wait_ready();
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        @(posedge clk);
        @(negedge clk);
        wr_valid = 1'b0;
        wait_ready();
    endtask

    task automatic wait_tval(input csr_word_t val);
        csr_word_t d;
        int        n;
        n = 0;
        read_csr(CSR_TVAL, d);
        while (d != val && n < 40) begin
            @(negedge clk);
            read_csr(CSR_TVAL, d);
            n++;
        end
        if (d != val) begin
            errors++;
            $display("TVAL never reached %0d at %0d ns", val, $time);
        end
    endtask

    task automatic test_scratch_rw();
        csr_addr_e addrs[5];
        csr_word_t old_v;
        csr_word_t new_v;
        csr_word_t d;
        addrs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID};
        foreach (addrs[i]) begin
            // Each register still holds its reset value
            old_v    = '0;
            new_v    = rand_word();
            wr_valid = 1'b1;
            wr_addr  = addrs[i];
            wr_data  = new_v;
            @(posedge clk);
            @(negedge clk);
            wr_valid = 1'b0;
            for (int e = 1; e <= 3; e++) begin
                read_csr(addrs[i], d);
                check_word("scratch before commit", d, old_v);
                check_bit("wr_ready while pending", wr_ready, 1'b0);
                @(negedge clk);
            end
            read_csr(addrs[i], d);
            check_word("scratch after commit", d, new_v);
            check_bit("wr_ready after commit", wr_ready, 1'b1);
        end
    endtask

    task automatic test_flush();
        csr_word_t old_v;
        csr_word_t d;
        old_v = rand_word();
        write_csr(CSR_SAVE1, old_v);
        read_csr(CSR_SAVE1, d);
        check_word("SAVE1 before flush", d, old_v);
        wr_valid = 1'b1;
        wr_addr  = CSR_SAVE1;
        wr_data  = ~old_v;
        @(posedge clk);
        @(negedge clk);
        wr_valid = 1'b0;
        flush    = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_bit("wr_ready after flush", wr_ready, 1'b1);
        repeat (4) @(negedge clk);
        read_csr(CSR_SAVE1, d);
        check_word("SAVE1 after flushed write", d, old_v);
        // Pipeline busy, write must stay parked
        pipe_idle = 1'b0;
        wr_valid  = 1'b1;
        @(posedge clk);
        @(negedge clk);
        wr_valid = 1'b0;
        repeat (10) @(negedge clk);
        read_csr(CSR_SAVE1, d);
        check_word("SAVE1 while pipeline busy", d, old_v);
        check_bit("wr_ready while pipeline busy", wr_ready, 1'b0);
        flush = 1'b1;
        @(negedge clk);
        flush     = 1'b0;
        pipe_idle = 1'b1;
        check_bit("wr_ready after second flush", wr_ready, 1'b1);
    endtask

    task automatic test_exception();
        csr_word_t era_v;
        csr_word_t badv_v;
        csr_word_t eentry_v;
        csr_word_t d;
        era_v    = rand_word();
        badv_v   = rand_word();
        eentry_v = rand_word();
        // Only VA above bit 5 is stored
        write_csr(CSR_EENTRY, eentry_v);
        read_csr(CSR_EENTRY, d);
        check_word("EENTRY read", d, eentry_v & 32'hffff_ffc0);
        check_word("EENTRY output", eentry, eentry_v & 32'hffff_ffc0);
        write_csr(CSR_CRMD, 32'h0000_000f);
        exception   = 1'b1;
        ecode_in    = ECODE_SYS;
        esubcode_in = 9'h055;
        era_in      = era_v;
        badv_in     = badv_v;
        badv_we     = 1'b1;
        @(negedge clk);
        badv_we = 1'b0;
        read_csr(CSR_PRMD, d);
        check_word("PRMD after entry", d, 32'h0000_0007);
        check_word("CRMD PLV/IE after entry", crmd & 32'h7, 32'h0);
        read_csr(CSR_ESTAT, d);
        check_ecode("ESTAT Ecode", ecode_e'(d[`ESTAT_ECODE]), ECODE_SYS);
        check_word("ESTAT EsubCode", 32'(d[`ESTAT_ESUBCODE]), 32'h055);
        read_csr(CSR_ERA, d);
        check_word("ERA after entry", d, era_v);
        check_word("ERA output", era, era_v);
        read_csr(CSR_BADV, d);
        check_word("BADV after entry", d, badv_v);
        exception = 1'b0;
        @(negedge clk);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        check_word("CRMD after ertn", crmd & 32'h7, 32'h0000_0007);
        write_csr(CSR_CRMD, 32'h0000_0008);
    endtask

    task automatic test_crmd_mode();
        write_csr(CSR_CRMD, 32'h0000_0018);
        check_word("CRMD with PG=DA=1", crmd, 32'h0000_0008);
        write_csr(CSR_CRMD, 32'h0000_0000);
        check_word("CRMD with PG=DA=0", crmd, 32'h0000_0008);
        write_csr(CSR_CRMD, 32'h0000_0010);
        check_word("CRMD with PG=1 DA=0", crmd, 32'h0000_0010);
        write_csr(CSR_CRMD, 32'h0000_0008);
        check_word("CRMD back to direct", crmd, 32'h0000_0008);
    endtask

    task automatic test_timer();
        localparam int K = 5;
        csr_word_t d;
        write_csr(CSR_TCFG, (K << 2) | 1);
        wait_tval(K);
        for (int i = K - 1; i >= 0; i--) begin
            @(negedge clk);
            read_csr(CSR_TVAL, d);
            check_word("TVAL countdown", d, csr_word_t'(i));
        end
        check_bit("ESTAT.TI at zero", estat[`ESTAT_IS_TI], 1'b1);
        @(negedge clk);
        read_csr(CSR_TVAL, d);
        check_word("TVAL holds in one-shot", d, 32'h0);
        write_csr(CSR_TICLR, 32'h1);
        check_bit("ESTAT.TI after TICLR", estat[`ESTAT_IS_TI], 1'b0);
        write_csr(CSR_TCFG, (K << 2) | 3);
        wait_tval(K);
        wait_tval(0);
        @(negedge clk);
        read_csr(CSR_TVAL, d);
        check_word("TVAL periodic reload", d, csr_word_t'(K));
        write_csr(CSR_TCFG, 32'h0);
        write_csr(CSR_TICLR, 32'h1);
    endtask

    task automatic test_interrupts();
        csr_word_t d;
        write_csr(CSR_ECFG, 32'h0000_1fff);
        read_csr(CSR_ECFG, d);
        check_word("ECFG LIE bit 10 reserved", d, 32'h0000_1bff);
        hw_int = 8'h01;
        @(negedge clk);
        check_bit("idle_over with IE=0", idle_over, 1'b1);
        check_bit("cpu_interrupt with IE=0", cpu_interrupt, 1'b0);
        write_csr(CSR_CRMD, 32'h0000_000c);
        check_bit("cpu_interrupt hw line", cpu_interrupt, 1'b1);
        write_csr(CSR_ECFG, 32'h0000_0800);
        check_bit("cpu_interrupt hw masked", cpu_interrupt, 1'b0);
        check_bit("idle_over hw masked", idle_over, 1'b1);
        hw_int = 8'h00;
        @(negedge clk);
        check_bit("idle_over no source", idle_over, 1'b0);
        write_csr(CSR_TCFG, (2 << 2) | 1);
        wait_tval(2);
        wait_tval(0);
        check_bit("cpu_interrupt from TI", cpu_interrupt, 1'b1);
        write_csr(CSR_TCFG, 32'h0);
        write_csr(CSR_TICLR, 32'h1);
        check_bit("cpu_interrupt after TICLR", cpu_interrupt, 1'b0);
        write_csr(CSR_CRMD, 32'h0000_0008);
        write_csr(CSR_ECFG, 32'h0);
    endtask

    task automatic report(input string name);
        $display("%-16s %s", name, (errors == errors_at_start) ? "ok" : "errors");
        errors_at_start = errors;
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        errors_at_start = 0;
        lfsr_state  = 16'd47893;
        aresetn     = 1'b0;
        wr_valid    = 1'b0;
        wr_addr     = CSR_SAVE0;
        wr_data     = '0;
        pipe_idle   = 1'b1;
        flush       = 1'b0;
        rd_addr     = CSR_CRMD;
        exception   = 1'b0;
        ertn        = 1'b0;
        ecode_in    = ECODE_INT;
        esubcode_in = '0;
        era_in      = '0;
        badv_in     = '0;
        badv_we     = 1'b0;
        hw_int      = '0;
        repeat (10) @(negedge clk);
        aresetn = 1'b1;
        @(negedge clk);
        test_scratch_rw();
        report("scratch_rw");
        test_flush();
        report("flush");
        test_exception();
        report("exception");
        test_crmd_mode();
        report("crmd_mode");
        test_timer();
        report("timer");
        test_interrupts();
        report("interrupts");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
